// File: Makefile
TOP := fetchFrontEnd_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: dv/clockGen.sv
/* testbench clock (100 ns) and active-low reset held for 8 cycles */

module clockGen (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // release on a rising edge, like any other input
    initial begin
        rst_o = 1'b0;
        repeat (8) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

// File: dv/fetchFrontEnd_chk.sv
/* concurrent checks of the fetch front end against a small reference
   model of the fetch PC, BTB, fetch queue and exception base */

`include "frontEnd_defs.svh"

module fetchFrontEnd_chk import frontEndPkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        cacheReq_o,
    input logic [11:0] cacheIndex_o,
    input logic        cacheIndexOk_i,
    input redirect_t   flush_i,
    input logic        excOccur_i,
    input logic [31:0] excPc_i,
    input csrWrite_t   csrWrite_i,
    input btbUpdate_t  btbUpdate_i,
    input logic        popStb_i,
    input fetchBlock_t headBlock_o,
    input logic        headValid_o,
    input logic [31:0] epc_o,
    // descriptor now held by the PC register
    input fetchBlock_t curBlock_i
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int DEPTH = `FQ_DEPTH;

    fetchBlock_t             modelCur;
    fetchBlock_t             expNext;
    fetchBlock_t             modelHead;
    fetchBlock_t             modelQ [$];
    int                      modelCount;
    logic [31:0]             modelBase;
    logic [`BTB_ENTRIES-1:0] btbValid;
    logic [31:0]             btbPc     [`BTB_ENTRIES];
    logic [31:0]             btbTarget [`BTB_ENTRIES];
    logic                    btbLast   [`BTB_ENTRIES];
    logic [IDX_W-1:0]        lookIdx;
    logic [IDX_W-1:0]        updIdx;
    logic                    btbHit;
    logic                    acceptNow;
    logic                    redirectNow;
    logic                    modelReq;
    int                      failCount = 0;

    // descriptor for a fetch starting at pc
    function automatic fetchBlock_t blockAt(logic [31:0] pc, logic delaySlot);
        fetchBlock_t b;
        b.vAddr         = pc & ~32'hF;
        b.needDelaySlot = delaySlot;
        b.hasException  = (pc[1:0] != 2'b00);
        b.excCode       = b.hasException ? `EXC_ADEL : 5'h00;
        if (b.hasException) begin
            b.instEnable = 4'b0000;
        end else if (delaySlot && pc[3:2] == 2'd0) begin
            b.instEnable = 4'b0001;
        end else begin
            // slots from the target word upward
            b.instEnable = 4'b1111 << pc[3:2];
        end
        return b;
    endfunction

    // --------------------
    // reference model
    // --------------------
    assign lookIdx     = modelCur.vAddr[4 +: IDX_W];
    assign updIdx      = btbUpdate_i.pc[4 +: IDX_W];
    assign btbHit      = btbValid[lookIdx] && (btbPc[lookIdx][31:4] == modelCur.vAddr[31:4]);
    assign acceptNow   = cacheReq_o && cacheIndexOk_i;
    assign redirectNow = excOccur_i || flush_i.valid;
    assign modelReq    = (modelCount < DEPTH) && !modelCur.hasException;

    // exception, then flush, then the predicted block
    always_comb begin
        if (excOccur_i) begin
            expNext = blockAt(modelBase, 1'b0);
        end else if (flush_i.valid) begin
            expNext = blockAt(flush_i.target, 1'b0);
        end else if (acceptNow && btbHit) begin
            expNext = blockAt(btbTarget[lookIdx], btbLast[lookIdx]);
        end else if (acceptNow) begin
            expNext = blockAt(modelCur.vAddr + 32'd16, 1'b0);
        end else begin
            expNext = modelCur;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            modelCur  <= blockAt(`START_POINT, 1'b0);
            modelBase <= `EXC_BASE_RESET;
            btbValid  <= '0;
            modelQ.delete();
        end else begin
            modelCur <= expNext;
            if (csrWrite_i.valid && csrWrite_i.sel == CSR_BASE) begin
                modelBase <= csrWrite_i.data & ~32'hF;
            end
            if (btbUpdate_i.valid) begin
                btbValid[updIdx]  <= 1'b1;
                btbPc[updIdx]     <= btbUpdate_i.pc;
                btbTarget[updIdx] <= btbUpdate_i.target;
                btbLast[updIdx]   <= btbUpdate_i.lastSlot;
            end
            // redirect drops everything queued, even this edge's block
            if (redirectNow) begin
                modelQ.delete();
            end else begin
                if (popStb_i && modelQ.size() != 0) begin
                    void'(modelQ.pop_front());
                end
                if (acceptNow) begin
                    modelQ.push_back(modelCur);
                end
            end
        end
        modelCount <= modelQ.size();
        if (modelQ.size() != 0) begin
            modelHead <= modelQ[0];
        end
    end

    // --------------------
    // reset and handshake
    // --------------------
    aReqInReset: assert property (@(posedge clk) !rst |-> !cacheReq_o)
        else begin
            failCount++;
            $error("ERR cacheReq_o exp 0 got %h", $sampled(cacheReq_o));
        end

    aHeadAfterReset: assert property (@(posedge clk) !rst |=> !headValid_o)
        else begin
            failCount++;
            $error("queue head reported valid right after reset");
        end

    aReqMatches: assert property (@(posedge clk) rst |-> cacheReq_o == modelReq)
        else begin
            failCount++;
            $error("ERR cacheReq_o exp %h got %h", $sampled(modelReq), $sampled(cacheReq_o));
        end

    aIndex: assert property (@(posedge clk) rst |-> cacheIndex_o == modelCur.vAddr[15:4])
        else begin
            failCount++;
            $error("ERR cacheIndex_o exp %h got %h",
                   $sampled(modelCur.vAddr[15:4]), $sampled(cacheIndex_o));
        end

    // mask, delay slot and ADEL fields of the block being fetched
    aCurBlock: assert property (@(posedge clk) rst |-> curBlock_i == modelCur)
        else begin
            failCount++;
            $error("ERR curBlock exp %h got %h", $sampled(modelCur), $sampled(curBlock_i));
        end

    // --------------------
    // queue contents
    // --------------------
    aHeadValid: assert property (@(posedge clk) rst |-> headValid_o == (modelCount != 0))
        else begin
            failCount++;
            $error("ERR headValid_o exp %h got %h", $sampled(modelCount != 0),
                   $sampled(headValid_o));
        end

    aHeadBlock: assert property (@(posedge clk) rst && headValid_o |-> headBlock_o == modelHead)
        else begin
            failCount++;
            $error("ERR headBlock_o exp %h got %h", $sampled(modelHead), $sampled(headBlock_o));
        end

    aFullStall: assert property (@(posedge clk) rst && modelCount == DEPTH |-> !cacheReq_o)
        else begin
            failCount++;
            $error("cache request raised while the fetch queue is full");
        end

    // ADEL holds fetch until a redirect
    aAdelStall: assert property (@(posedge clk) rst && modelCur.hasException |-> !cacheReq_o)
        else begin
            failCount++;
            $error("cache request raised with a misaligned block pending");
        end

    // --------------------
    // redirects
    // --------------------
    aRedirectClears: assert property (@(posedge clk) rst && redirectNow |=> !headValid_o)
        else begin
            failCount++;
            $error("queue not emptied by a redirect");
        end

    aEpc: assert property (@(posedge clk) rst && excOccur_i |=> epc_o == $past(excPc_i))
        else begin
            failCount++;
            $error("ERR epc_o exp %h got %h", $past(excPc_i), $sampled(epc_o));
        end

    aExcWins: assert property (@(posedge clk)
            rst && excOccur_i && flush_i.valid |=> cacheIndex_o == $past(modelBase[15:4]))
        else begin
            failCount++;
            $error("ERR cacheIndex_o exp %h got %h", $past(modelBase[15:4]),
                   $sampled(cacheIndex_o));
        end

endmodule

// File: dv/fetchFrontEnd_tb.sv
/* fetch front end testbench: LFSR-driven index-ok, pops and redirect
   targets, phase waits with timeouts, checker bound into the UUT */

`include "frontEnd_defs.svh"

module fetchFrontEnd_tb import frontEndPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          WAIT_LIMIT = 400;
    localparam logic [31:0] EXC_BASE   = `EXC_BASE_RESET;

    logic        clk;
    logic        rst;
    logic        cacheReq;
    logic [11:0] cacheIndex;
    logic        cacheIndexOk;
    redirect_t   flush;
    logic        excOccur;
    logic [31:0] excPc;
    csrWrite_t   csrWrite;
    btbUpdate_t  btbUpdate;
    logic        popStb;
    fetchBlock_t headBlock;
    logic        headValid;
    logic [31:0] epc;
    logic [31:0] lfsrState;
    // decode pops only while set
    logic        popEnable;
    logic [31:0] newBase;

    clockGen u_clockGen (
        .clk_o (clk),
        .rst_o (rst)
    );

    fetchFrontEnd UUT (
        .clk            (clk),
        .rst            (rst),
        .cacheReq_o     (cacheReq),
        .cacheIndex_o   (cacheIndex),
        .cacheIndexOk_i (cacheIndexOk),
        .flush_i        (flush),
        .excOccur_i     (excOccur),
        .excPc_i        (excPc),
        .csrWrite_i     (csrWrite),
        .btbUpdate_i    (btbUpdate),
        .popStb_i       (popStb),
        .headBlock_o    (headBlock),
        .headValid_o    (headValid),
        .epc_o          (epc)
    );

    bind fetchFrontEnd fetchFrontEnd_chk chk (.*, .curBlock_i (curBlock));

    // --------------------
    // helpers
    // --------------------
    // galois LFSR, one step per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return bits;
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on failure");
    endtask

    // one edge, fresh random ready and pop, strobes back to idle
    task automatic nextEdge();
        @(posedge clk);
        cacheIndexOk <= (randBits(2) != 32'd0);
        popStb       <= popEnable && (randBits(1) == 32'd1);
        flush        <= '0;
        excOccur     <= 1'b0;
        csrWrite     <= '0;
        btbUpdate    <= '0;
    endtask

    task automatic idleCycles(int n);
        for (int i = 0; i < n; i++) begin
            nextEdge();
        end
    endtask

    task automatic waitReset();
        int cycles;
        cycles = 0;
        while (!rst && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst) failRun("reset was never released");
    endtask

    // counts edges where request and index-ok meet
    task automatic waitAccepts(int n);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (seen < n && cycles < WAIT_LIMIT) begin
            nextEdge();
            cycles++;
            if (cacheReq && cacheIndexOk) seen++;
        end
        if (seen < n) failRun("timed out waiting for accepted cache requests");
    endtask

    task automatic waitIndex(logic [11:0] idx);
        int cycles;
        cycles = 0;
        while (cacheIndex != idx && cycles < WAIT_LIMIT) begin
            nextEdge();
            cycles++;
        end
        if (cacheIndex != idx) failRun("timed out waiting for the expected cache index");
    endtask

    task automatic waitStall();
        int cycles;
        cycles = 0;
        while (cacheReq && cycles < WAIT_LIMIT) begin
            nextEdge();
            cycles++;
        end
        if (cacheReq) failRun("cache request never dropped with pops withheld");
    endtask

    task automatic sendFlush(logic [31:0] flushTarget);
        nextEdge();
        flush <= '{valid: 1'b1, target: flushTarget};
    endtask

    task automatic sendBtbUpdate(logic [31:0] branchPc, logic [31:0] branchTarget,
                                 logic inLastSlot);
        nextEdge();
        btbUpdate <= '{valid: 1'b1, pc: branchPc, target: branchTarget, lastSlot: inLastSlot};
    endtask

    task automatic sendException(logic [31:0] faultPc, logic withFlush);
        nextEdge();
        excOccur <= 1'b1;
        excPc    <= faultPc;
        if (withFlush) flush <= '{valid: 1'b1, target: randBits(32) & ~32'h3};
    endtask

    task automatic writeBase(logic [31:0] baseValue);
        nextEdge();
        csrWrite <= '{valid: 1'b1, sel: CSR_BASE, data: baseValue};
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial begin
        lfsrState    = 32'h02dc_01b3;
        popEnable    = 1'b1;
        cacheIndexOk = 1'b0;
        flush        = '0;
        excOccur     = 1'b0;
        excPc        = '0;
        csrWrite     = '0;
        btbUpdate    = '0;
        popStb       = 1'b0;

        // boot block, then sequential blocks from an empty BTB
        waitReset();
        waitAccepts(12);

        // 1000 -> 1010 -> 2000 -> 3000 (delay slot only) -> 3010
        sendBtbUpdate(32'h0000_1010, 32'h0000_2000, 1'b0);
        sendBtbUpdate(32'h0000_2000, 32'h0000_3000, 1'b1);
        sendFlush(32'h0000_1000);
        waitIndex(12'h301);

        // each word position
        for (int p = 0; p < 4; p++) begin
            sendFlush((randBits(32) & 32'hFFFF_FFF0) | (p << 2));
            waitAccepts(2);
        end
        // misaligned target stalls fetch until redirected
        sendFlush(randBits(32) | 32'h0000_0001);
        idleCycles(10);
        sendFlush(32'h0000_4000);
        waitAccepts(2);

        // exception beats a same-cycle flush
        sendException(randBits(32), 1'b1);
        waitIndex(EXC_BASE[15:4]);
        waitAccepts(3);

        // back-pressure from a full queue
        popEnable = 1'b0;
        waitStall();
        idleCycles(6);
        popEnable = 1'b1;
        waitAccepts(8);

        // software-written base, aligned by the register
        newBase = randBits(32);
        writeBase(newBase);
        sendException(randBits(32), 1'b0);
        waitIndex(newBase[15:4]);
        waitAccepts(2);

        // assertions of the last edge act after that edge
        @(negedge clk);
        if (UUT.chk.failCount == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            failRun("the checker recorded assertion failures");
        end
    end

    // stop at the first failed assertion
    always @(posedge clk) begin
        if (UUT.chk.failCount != 0) failRun("a checker assertion failed");
    end

endmodule

// File: source/branchTargetBuffer.sv
/* direct-mapped branch target buffer: block lookup with target or
   sequential fallback, single-strobe entry update */

`include "frontEnd_defs.svh"

module branchTargetBuffer import frontEndPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] lookupPc_i,
    output prediction_t prediction_o,
    input  btbUpdate_t  update_i
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    // block offset is 4 bits, the rest above the index is tag
    localparam int TAG_W = 32 - 4 - IDX_W;

    // --------------------
    // table storage
    // --------------------
    logic [`BTB_ENTRIES-1:0] entryValid;
    logic [TAG_W-1:0]        entryTag    [`BTB_ENTRIES];
    logic [31:0]             entryTarget [`BTB_ENTRIES];
    logic                    entryLast   [`BTB_ENTRIES];

    logic [IDX_W-1:0] lookupIdx;
    logic [TAG_W-1:0] lookupTag;
    logic [IDX_W-1:0] updateIdx;
    logic [TAG_W-1:0] updateTag;
    logic             hit;
    logic [31:0]      seqPc;

    assign lookupIdx = lookupPc_i[4 +: IDX_W];
    assign lookupTag = lookupPc_i[31 -: TAG_W];
    assign updateIdx = update_i.pc[4 +: IDX_W];
    assign updateTag = update_i.pc[31 -: TAG_W];

    // --------------------
    // lookup
    // --------------------
    assign hit   = entryValid[lookupIdx] && (entryTag[lookupIdx] == lookupTag);
    // fall through to the following block
    assign seqPc = {lookupPc_i[31:4], 4'b0000} + 32'd16;

    always_comb begin
        if (hit) begin
            prediction_o.nextPc        = entryTarget[lookupIdx];
            prediction_o.needDelaySlot = entryLast[lookupIdx];
        end else begin
            prediction_o.nextPc        = seqPc;
            prediction_o.needDelaySlot = 1'b0;
        end
    end

    // --------------------
    // update
    // --------------------
    // valid bits need a clean start
    always_ff @(posedge clk) begin
        if (!rst) begin
            entryValid <= '0;
        end else if (update_i.valid) begin
            entryValid[updateIdx] <= 1'b1;
        end
    end

    // overwrite, no replacement choice in a direct-mapped table
    always_ff @(posedge clk) begin
        if (update_i.valid) begin
            entryTag[updateIdx]    <= updateTag;
            entryTarget[updateIdx] <= update_i.target;
            entryLast[updateIdx]   <= update_i.lastSlot;
        end
    end

endmodule

// File: source/exceptionVectorRegs.sv
/* exception base and EPC registers, CSR writable,
   exception strobe turned into a redirect to the base */

`include "frontEnd_defs.svh"

module exceptionVectorRegs import frontEndPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  csrWrite_t   csrWrite_i,
    input  logic        excOccur_i,
    input  logic [31:0] excPc_i,
    output redirect_t   excRedirect_o,
    output logic [31:0] epc_o,
    output logic [31:0] excBase_o
);

    logic [31:0] excBase;
    logic [31:0] epc;

    // --------------------
    // base register
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            excBase <= `EXC_BASE_RESET;
        end else if (csrWrite_i.valid && csrWrite_i.sel == CSR_BASE) begin
            // vector must land on a block boundary
            excBase <= {csrWrite_i.data[31:4], 4'b0000};
        end
    end

    // --------------------
    // EPC register
    // --------------------
    // a commit exception beats a software write
    always_ff @(posedge clk) begin
        if (!rst) begin
            epc <= '0;
        end else if (excOccur_i) begin
            epc <= excPc_i;
        end else if (csrWrite_i.valid && csrWrite_i.sel == CSR_EPC) begin
            epc <= csrWrite_i.data;
        end
    end

    // same-cycle redirect, base as it stands before any write this cycle
    assign excRedirect_o.valid  = excOccur_i;
    assign excRedirect_o.target = excBase;
    assign epc_o                = epc;
    assign excBase_o            = excBase;

endmodule

// File: source/fetchFrontEnd.sv
/* fetch front end top: PC register, BTB, fetch queue and
   exception vector registers wired to cache, commit and decode */

module fetchFrontEnd import frontEndPkg::*; (
    input  logic        clk,
    input  logic        rst,
    // instruction cache
    output logic        cacheReq_o,
    output logic [11:0] cacheIndex_o,
    input  logic        cacheIndexOk_i,
    // branch mispredict from the back end
    input  redirect_t   flush_i,
    // commit-stage exception and CSR access
    input  logic        excOccur_i,
    input  logic [31:0] excPc_i,
    input  csrWrite_t   csrWrite_i,
    input  btbUpdate_t  btbUpdate_i,
    // decode side
    input  logic        popStb_i,
    output fetchBlock_t headBlock_o,
    output logic        headValid_o,
    output logic [31:0] epc_o
);

    // --------------------
    // internal wires
    // --------------------
    fetchBlock_t curBlock;
    prediction_t prediction;
    redirect_t   excRedirect;
    logic        accept;
    logic        queueFull;

    pcRegister u_pcRegister (
        .clk            (clk),
        .rst            (rst),
        .cacheReq_o     (cacheReq_o),
        .cacheIndex_o   (cacheIndex_o),
        .cacheIndexOk_i (cacheIndexOk_i),
        .stopFetch_i    (queueFull),
        .prediction_i   (prediction),
        .flush_i        (flush_i),
        .exc_i          (excRedirect),
        .curBlock_o     (curBlock),
        .accept_o       (accept)
    );

    // predicts the block after the one now requested
    branchTargetBuffer u_branchTargetBuffer (
        .clk          (clk),
        .rst          (rst),
        .lookupPc_i   (curBlock.vAddr),
        .prediction_o (prediction),
        .update_i     (btbUpdate_i)
    );

    // any redirect empties the queue on its edge
    fetchQueue u_fetchQueue (
        .clk         (clk),
        .rst         (rst),
        .push_i      (accept),
        .pushBlock_i (curBlock),
        .pop_i       (popStb_i),
        .clear_i     (flush_i.valid | excRedirect.valid),
        .headBlock_o (headBlock_o),
        .headValid_o (headValid_o),
        .full_o      (queueFull)
    );

    // base only observed through the redirect here
    exceptionVectorRegs u_exceptionVectorRegs (
        .clk           (clk),
        .rst           (rst),
        .csrWrite_i    (csrWrite_i),
        .excOccur_i    (excOccur_i),
        .excPc_i       (excPc_i),
        .excRedirect_o (excRedirect),
        .epc_o         (epc_o),
        .excBase_o     ()
    );

endmodule

// File: source/fetchQueue.sv
/* circular fetch queue of accepted block descriptors,
   full flag toward the PC register and a clear on redirect */

`include "frontEnd_defs.svh"

module fetchQueue import frontEndPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        push_i,
    input  fetchBlock_t pushBlock_i,
    input  logic        pop_i,
    input  logic        clear_i,
    output fetchBlock_t headBlock_o,
    output logic        headValid_o,
    output logic        full_o
);

    localparam int PTR_W = $clog2(`FQ_DEPTH);

    fetchBlock_t      queueMem [`FQ_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    // one wider than the pointers to tell full from empty
    logic [PTR_W:0]   count;
    logic             doPush;
    logic             doPop;

    // --------------------
    // status
    // --------------------
    assign full_o      = (count == (PTR_W + 1)'(`FQ_DEPTH));
    assign headValid_o = (count != '0);
    assign headBlock_o = queueMem[rdPtr];

    // push when full and pop when empty are dropped
    assign doPush = push_i & ~full_o;
    assign doPop  = pop_i & headValid_o;

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clear_i) begin
            // redirect wipes everything, including a same-cycle push
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // push and pop together leave count alone
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            queueMem[wrPtr] <= pushBlock_i;
        end
    end

endmodule

// File: source/frontEndPkg.sv
/* shared structs of the fetch front end: fetch block descriptor,
   redirect, BTB update, prediction and CSR write */

package frontEndPkg;

    // --------------------
    // fetch path
    // --------------------
    // one accepted block of four instructions
    typedef struct packed {
        logic [31:0] vAddr;
        // bit i set means slot i is wanted
        logic [3:0]  instEnable;
        logic        hasException;
        logic [4:0]  excCode;
        logic        needDelaySlot;
    } fetchBlock_t;

    // flush or exception redirect
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

    // --------------------
    // predictor
    // --------------------
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] target;
        // branch sits in slot 3, delay slot lives in the next block
        logic        lastSlot;
    } btbUpdate_t;

    typedef struct packed {
        logic [31:0] nextPc;
        logic        needDelaySlot;
    } prediction_t;

    // --------------------
    // exception CSRs
    // --------------------
    typedef enum logic {
        CSR_BASE = 1'b0,
        CSR_EPC  = 1'b1
    } csrSel_t;

    typedef struct packed {
        logic        valid;
        csrSel_t     sel;
        logic [31:0] data;
    } csrWrite_t;

endpackage

// File: source/frontEnd_defs.svh
/* fetch front end macros: reset start point, ADEL code,
   BTB size, fetch-queue depth and exception base reset value */

`ifndef FRONTEND_DEFS_SVH
`define FRONTEND_DEFS_SVH

// --------------------
// fetch addresses
// --------------------
// boot vector, block aligned
`define START_POINT     32'hBFC0_0000
// exception entry after reset, 16-byte aligned
`define EXC_BASE_RESET  32'hBFC0_0380

// address error on load / ifetch
`define EXC_ADEL        5'h04

// --------------------
// table and queue sizes
// --------------------
// power of two, indexed by block address
`define BTB_ENTRIES     16
`define FQ_DEPTH        4

`endif

// File: source/pcRegister.sv
/* fetch PC register: next-PC select, block alignment, enable mask,
   ADEL detection and the sram-like request/index-ok handshake */

`include "frontEnd_defs.svh"

module pcRegister import frontEndPkg::*; (
    input  logic        clk,
    input  logic        rst,
    // instruction cache request side
    output logic        cacheReq_o,
    output logic [11:0] cacheIndex_o,
    input  logic        cacheIndexOk_i,
    // queue back-pressure
    input  logic        stopFetch_i,
    // next block from the BTB
    input  prediction_t prediction_i,
    // redirects, exception has priority
    input  redirect_t   flush_i,
    input  redirect_t   exc_i,
    output fetchBlock_t curBlock_o,
    output logic        accept_o
);

    fetchBlock_t curBlock;
    fetchBlock_t nextBlock;
    logic        redirectNow;
    logic [31:0] nextPc;
    logic        delaySlotPath;
    logic [1:0]  position;
    logic [3:0]  slotMask;
    logic        misaligned;

    // --------------------
    // next PC select
    // --------------------
    always_comb begin
        redirectNow = exc_i.valid | flush_i.valid;
        // delay slot hint only counts on the prediction path
        delaySlotPath = 1'b0;
        if (exc_i.valid) begin
            nextPc = exc_i.target;
        end else if (flush_i.valid) begin
            nextPc = flush_i.target;
        end else begin
            nextPc = prediction_i.nextPc;
            delaySlotPath = prediction_i.needDelaySlot;
        end
    end

    // --------------------
    // mask and alignment
    // --------------------
    assign position   = nextPc[3:2];
    assign misaligned = |nextPc[1:0];

    always_comb begin
        case (position)
            // only the delay slot when the branch was in slot 3
            2'd0:    slotMask = delaySlotPath ? 4'b0001 : 4'b1111;
            2'd1:    slotMask = 4'b1110;
            2'd2:    slotMask = 4'b1100;
            default: slotMask = 4'b1000;
        endcase
    end

    always_comb begin
        nextBlock.vAddr         = {nextPc[31:4], 4'b0000};
        // misaligned target wants nothing
        nextBlock.instEnable    = misaligned ? 4'b0000 : slotMask;
        nextBlock.hasException  = misaligned;
        nextBlock.excCode       = misaligned ? `EXC_ADEL : 5'd0;
        nextBlock.needDelaySlot = delaySlotPath;
    end

    // --------------------
    // registered descriptor
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            curBlock <= '{vAddr: `START_POINT, instEnable: 4'hF, hasException: 1'b0,
                          excCode: 5'd0, needDelaySlot: 1'b0};
        end else begin
            // advance on acceptance, redirects load regardless
            if (accept_o || redirectNow) begin
                curBlock <= nextBlock;
            end
        end
    end

    // stall on full queue or a pending ADEL until redirected
    assign cacheReq_o   = rst & ~stopFetch_i & ~curBlock.hasException;
    assign accept_o     = cacheReq_o & cacheIndexOk_i;
    assign cacheIndex_o = curBlock.vAddr[15:4];
    assign curBlock_o   = curBlock;

endmodule

// File: tb.f
+incdir+source
source/frontEndPkg.sv
source/pcRegister.sv
source/branchTargetBuffer.sv
source/fetchQueue.sv
source/exceptionVectorRegs.sv
source/fetchFrontEnd.sv
dv/clockGen.sv
dv/fetchFrontEnd_chk.sv
dv/fetchFrontEnd_tb.sv
